/* list.f */
+incdir+src
src/mem_pkg.sv
src/lat_lfsr.sv
src/lat_cfg_regs.sv
src/sram_array.sv
src/axi_rd_ctrl.sv
src/axi_wr_ctrl.sv
src/sram_slave_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= \*\*\* TEST PASSED \*\*\*

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv src/*.svh tests/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module tb_top import mem_pkg::*; ;

  localparam int TMO = 1000;

  logic clk, rstn;
  logic [31:0] araddr, awaddr, wdata;
  logic arvalid, rready, awvalid, wvalid, bready, cfg_we;
  logic [3:0] wstrb;
  logic [7:0] cfg_wdata;
  cfg_reg_t cfg_addr;
  logic arready, rvalid, awready, wready, bvalid;
  logic [31:0] rdata;
  logic [7:0] cfg_rdata;
  resp_t rresp, bresp;
  int seed = 32'hb7bb;
  int tmo_errs = 0;
  int chk_errors;
  int wr_idx_busy = -1;
  int rd_idx_busy = -1;
  bit written [256];

  sram_slave_top sram_slave_top_i (.*);

  tb_checker tb_checker (.*, .errors(chk_errors));

  initial begin
    clk = 0;
    forever #10 clk = ~clk;
  end

  task automatic report_timeout(input string what);
    tmo_errs++;
    $display("TIMEOUT: %s", what);
  endtask

  task automatic cfg_write(input cfg_reg_t a, input logic [7:0] d);
    @(negedge clk);
    cfg_we = 1;
    cfg_addr = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we = 0;
    @(posedge clk); // Checker compares the readback here
  endtask

  task automatic cfg_look(input cfg_reg_t a);
    @(negedge clk);
    cfg_addr = a;
    @(posedge clk);
  endtask

  task automatic do_read(input logic [31:0] addr, input int hold);
    int n;
    bit hs;
    @(negedge clk);
    araddr = addr;
    arvalid = 1;
    n = 0;
    hs = 0;
    while (!hs && n < TMO) begin
      @(posedge clk);
      hs = arready;
      n++;
    end
    if (!hs) report_timeout("read address handshake never came");
    @(negedge clk);
    arvalid = 0;
    n = 0;
    hs = 0;
    while (!hs && n < TMO) begin
      rready = (n >= hold) && (($random(seed) & 3) != 0); // Random back-pressure
      @(posedge clk);
      hs = rvalid && rready;
      n++;
      if (!hs) @(negedge clk);
    end
    if (!hs) report_timeout("read data handshake never came");
    @(negedge clk);
    rready = 0;
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [3:0] strb, input int hold);
    int order, skew, n, n_aw, n_w;
    bit hs, hs_aw, hs_w;
    order = {$random(seed)} % 3; // 0 together, 1 AW first, 2 W first
    skew = {$random(seed)} % 4;
    @(negedge clk);
    fork
      begin
        n_aw = 0;
        hs_aw = 0;
        repeat (order == 2 ? skew : 0) @(negedge clk);
        awaddr = addr;
        awvalid = 1;
        while (!hs_aw && n_aw < TMO) begin
          @(posedge clk);
          hs_aw = awready;
          n_aw++;
        end
        if (!hs_aw) report_timeout("write address handshake never came");
        @(negedge clk);
        awvalid = 0;
      end
      begin
        n_w = 0;
        hs_w = 0;
        repeat (order == 1 ? skew : 0) @(negedge clk);
        wdata = $random(seed);
        wstrb = strb;
        wvalid = 1;
        while (!hs_w && n_w < TMO) begin
          @(posedge clk);
          hs_w = wready;
          n_w++;
        end
        if (!hs_w) report_timeout("write data handshake never came");
        @(negedge clk);
        wvalid = 0;
      end
    join
    n = 0;
    hs = 0;
    while (!hs && n < TMO) begin
      bready = (n >= hold) && (($random(seed) & 3) != 0);
      @(posedge clk);
      hs = bvalid && bready;
      n++;
      if (!hs) @(negedge clk);
    end
    if (!hs) report_timeout("write response handshake never came");
    @(negedge clk);
    bready = 0;
  endtask

  task automatic write_idx(input int idx, input int hold);
    logic [3:0] strb;
    strb = written[idx] ? 4'($random(seed)) : 4'hf; // First write fills the word
    wr_idx_busy = idx;
    do_write({22'b0, idx[7:0], 2'b00}, strb, hold);
    written[idx] = 1;
    wr_idx_busy = -1;
  endtask

  // Written word with no write in flight, or -1
  function automatic int pick_idx();
    int idx;
    for (int t = 0; t < 64; t++) begin
      idx = {$random(seed)} % 32;
      if (written[idx] && idx != wr_idx_busy) return idx;
    end
    return -1;
  endfunction

  // Random word with no read in flight
  function automatic int free_wr_idx();
    int idx;
    idx = {$random(seed)} % 32;
    if (idx == rd_idx_busy) idx = (idx + 1) % 32;
    return idx;
  endfunction

  task automatic read_some(input int count, input int hold);
    int idx;
    for (int i = 0; i < count; i++) begin
      idx = pick_idx();
      if (idx < 0) begin
        @(negedge clk);
      end else begin
        rd_idx_busy = idx;
        do_read({22'b0, idx[7:0], 2'b00}, hold);
        rd_idx_busy = -1;
      end
    end
  endtask

  initial begin
    logic [31:0] up;
    int idx;
    rstn = 1;
    {araddr, awaddr, wdata, wstrb, cfg_wdata} = '0;
    {arvalid, rready, awvalid, wvalid, bready, cfg_we} = '0;
    cfg_addr = CFG_MIN_LAT;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 0;

    cfg_look(CFG_MIN_LAT);
    cfg_look(CFG_RAND_MASK);
    cfg_look(CFG_SEED);
    cfg_write(CFG_MIN_LAT, 8'h05);
    cfg_write(CFG_RAND_MASK, 8'h33);
    cfg_write(CFG_SEED, 8'h5c);
    cfg_write(CFG_SEED, 8'h00);

    // Fixed latency
    cfg_write(CFG_RAND_MASK, 8'h00);
    for (int i = 0; i < 4; i++) begin
      cfg_write(CFG_MIN_LAT, 8'(i * 3));
      write_idx(i, 0);
      do_read({22'b0, 8'(i), 2'b00}, 0);
    end

    // Random traffic on both channels
    cfg_write(CFG_MIN_LAT, 8'h01);
    cfg_write(CFG_RAND_MASK, 8'h07);
    cfg_write(CFG_SEED, 8'h3d);
    fork
      for (int i = 0; i < 60; i++) write_idx(free_wr_idx(), 0);
      read_some(60, 0);
    join

    // Out of range
    for (int i = 0; i < 4; i++) begin
      up = {$random(seed)} | 32'h400;
      do_read({up[31:10], 10'h0}, 0);
      idx = pick_idx();
      if (idx >= 0) begin
        do_write({up[31:10], idx[7:0], 2'b00}, 4'hf, 0);
        do_read({22'b0, idx[7:0], 2'b00}, 0);
      end
    end

    // One channel held, the other keeps going
    fork
      write_idx(40, 40);
      read_some(4, 0);
    join
    fork
      do_read({22'b0, 8'd40, 2'b00}, 40);
      for (int i = 0; i < 3; i++) write_idx(i + 8, 0);
    join

    repeat (5) @(negedge clk);
    $display("Errors: %0d check, %0d timeout", chk_errors, tmo_errs);
    if (chk_errors == 0 && tmo_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module tb_checker import mem_pkg::*; (
  input  wire                       clk,
  input  wire                       rstn,
  input  wire  [`MEM_ADDR_W-1:0]    araddr,
  input  wire                       arvalid,
  input  wire                       arready,
  input  wire  [`MEM_DATA_W-1:0]    rdata,
  input  var resp_t                 rresp,
  input  wire                       rvalid,
  input  wire                       rready,
  input  wire  [`MEM_ADDR_W-1:0]    awaddr,
  input  wire                       awvalid,
  input  wire                       awready,
  input  wire  [`MEM_DATA_W-1:0]    wdata,
  input  wire  [`MEM_DATA_W/8-1:0]  wstrb,
  input  wire                       wvalid,
  input  wire                       wready,
  input  var resp_t                 bresp,
  input  wire                       bvalid,
  input  wire                       bready,
  input  wire                       cfg_we,
  input  var cfg_reg_t              cfg_addr,
  input  wire  [7:0]                cfg_wdata,
  input  wire  [7:0]                cfg_rdata,
  output int                        errors
);

  logic [`MEM_DATA_W-1:0] mem [256]; // Model memory
  logic [7:0] m_min, m_mask, m_seed, exp_cfg;
  logic [`MEM_ADDR_W-1:0] rd_addr, wr_addr;
  logic [`MEM_DATA_W-1:0] wr_dat, r_hold, exp_d;
  logic [3:0] wr_st;
  resp_t rr_hold, exp_r;
  int cyc, rd_k, rd_d, rd_span, wr_k, wr_d, wr_span;
  bit was_rst, rd_pend, rd_seen, r_wait;
  bit aw_got, w_got, b_seen, aw_hs, w_hs;

  task automatic flag_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    errors++;
    $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
  endtask

  task automatic flag_problem(input string what);
    errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  // Exact when the mask is zero, otherwise bounded by min_lat and rand_mask
  task automatic check_latency(input string name, input int min_d, input int span,
                               input int act);
    if (span == 0) begin
      if (act != min_d) flag_mismatch(name, 32'(min_d), 32'(act));
    end else if (act < min_d || act > min_d + span) begin
      flag_problem({name, " outside the min_lat and rand_mask range"});
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[b*8 +: 8] = data[b*8 +: 8];
    end
    return w;
  endfunction

  initial errors = 0;

  // Values seen here are the ones settled after the previous edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rstn) begin
      m_min = 8'h00;
      m_mask = 8'h0f;
      m_seed = 8'haa;
      rd_pend = 0;
      r_wait = 0;
      aw_got = 0;
      w_got = 0;
      was_rst = 1;
    end else begin
      if (was_rst) begin
        was_rst = 0;
        if (rvalid || bvalid) flag_problem("valid high right after reset");
        if (!(arready && awready && wready)) flag_problem("a ready low right after reset");
      end
      case (cfg_addr)
        CFG_MIN_LAT:   exp_cfg = m_min;
        CFG_RAND_MASK: exp_cfg = m_mask;
        CFG_SEED:      exp_cfg = m_seed;
        default:       exp_cfg = 8'h00;
      endcase
      if (cfg_rdata !== exp_cfg) flag_mismatch("cfg_rdata", 32'(exp_cfg), 32'(cfg_rdata));

      // Read channel
      if (r_wait && rdata !== r_hold) flag_mismatch("rdata held", r_hold, rdata);
      if (r_wait && rresp !== rr_hold) flag_mismatch("rresp held", 32'(rr_hold), 32'(rresp));
      r_wait = rvalid && !rready;
      r_hold = rdata;
      rr_hold = rresp;
      if (rd_pend && arready) flag_problem("arready high while a read is outstanding");
      if (rvalid && !rd_pend) flag_problem("rvalid without a read request");
      if (rvalid && rd_pend && !rd_seen) begin
        rd_seen = 1;
        check_latency("read latency", rd_d, rd_span, cyc - 1 - rd_k);
      end
      if (rvalid && rready && rd_pend) begin
        exp_d = (|rd_addr[31:10]) ? 32'h0 : mem[rd_addr[9:2]];
        exp_r = (|rd_addr[31:10]) ? RESP_SLVERR : RESP_OKAY;
        if (rdata !== exp_d) flag_mismatch("rdata", exp_d, rdata);
        if (rresp !== exp_r) flag_mismatch("rresp", 32'(exp_r), 32'(rresp));
        rd_pend = 0;
      end
      if (arvalid && arready) begin
        rd_pend = 1;
        rd_seen = 0;
        rd_k = cyc;
        rd_d = 2 + int'(m_min);
        rd_span = int'(m_mask);
        rd_addr = araddr;
      end

      // Write channel
      if (aw_got && awready) flag_problem("awready high while a write is outstanding");
      if (w_got && wready) flag_problem("wready high while a write is outstanding");
      if (bvalid && !(aw_got && w_got)) flag_problem("bvalid without a complete write");
      if (bvalid && aw_got && w_got && !b_seen) begin
        b_seen = 1;
        check_latency("write latency", wr_d, wr_span, cyc - 1 - wr_k);
      end
      if (bvalid && bready && aw_got && w_got) begin
        exp_r = (|wr_addr[31:10]) ? RESP_SLVERR : RESP_OKAY;
        if (bresp !== exp_r) flag_mismatch("bresp", 32'(exp_r), 32'(bresp));
        if (exp_r == RESP_OKAY) mem[wr_addr[9:2]] = merge_bytes(mem[wr_addr[9:2]], wr_dat, wr_st);
        aw_got = 0;
        w_got = 0;
      end
      aw_hs = awvalid && awready;
      w_hs = wvalid && wready;
      if (aw_hs) begin
        aw_got = 1;
        wr_addr = awaddr;
      end
      if (w_hs) begin
        w_got = 1;
        wr_dat = wdata;
        wr_st = wstrb;
      end
      if ((aw_hs || w_hs) && aw_got && w_got) begin // Pair completes on this edge
        wr_k = cyc;
        wr_d = 2 + int'(m_min);
        wr_span = int'(m_mask);
        b_seen = 0;
      end

      if (cfg_we) begin
        case (cfg_addr)
          CFG_MIN_LAT:   m_min = cfg_wdata;
          CFG_RAND_MASK: m_mask = cfg_wdata;
          CFG_SEED:      m_seed = cfg_wdata;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* src/sram_slave_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module sram_slave_top import mem_pkg::*; (
  input  wire                       clk,
  input  wire                       rstn,
  // Read address and data
  input  wire  [`MEM_ADDR_W-1:0]    araddr,
  input  wire                       arvalid,
  output logic                      arready,
  output logic [`MEM_DATA_W-1:0]    rdata,
  output resp_t                     rresp,
  output logic                      rvalid,
  input  wire                       rready,
  // Write address, data and response
  input  wire  [`MEM_ADDR_W-1:0]    awaddr,
  input  wire                       awvalid,
  output logic                      awready,
  input  wire  [`MEM_DATA_W-1:0]    wdata,
  input  wire  [`MEM_DATA_W/8-1:0]  wstrb,
  input  wire                       wvalid,
  output logic                      wready,
  output resp_t                     bresp,
  output logic                      bvalid,
  input  wire                       bready,
  // Latency configuration
  input  wire                       cfg_we,
  input  var cfg_reg_t              cfg_addr,
  input  wire  [7:0]                cfg_wdata,
  output logic [7:0]                cfg_rdata
);

  logic [7:0]                  min_lat;
  logic [7:0]                  rand_mask;
  logic [7:0]                  seed;
  logic                        seed_load;
  logic [7:0]                  lfsr_out;
  logic                        rd_en;
  logic [`MEM_DEPTH_LOG2-1:0]  rd_index;
  logic [`MEM_DATA_W-1:0]      rd_data;
  logic                        wr_en;
  logic [`MEM_DEPTH_LOG2-1:0]  wr_index;
  logic [`MEM_DATA_W-1:0]      wr_data;
  logic [`MEM_DATA_W/8-1:0]    wr_strb;

  lat_cfg_regs lat_cfg_regs_i (
    .clk       (clk),
    .rstn      (rstn),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .min_lat   (min_lat),
    .rand_mask (rand_mask),
    .seed      (seed),
    .seed_load (seed_load)
  );

  lat_lfsr lat_lfsr_i (
    .clk       (clk),
    .rstn      (rstn),
    .seed_load (seed_load),
    .seed      (seed),
    .lfsr_out  (lfsr_out)
  );

  sram_array sram_array_i (
    .clk      (clk),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb)
  );

  axi_rd_ctrl axi_rd_ctrl_i (
    .clk       (clk),
    .rstn      (rstn),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .min_lat   (min_lat),
    .rand_mask (rand_mask),
    .lfsr_out  (lfsr_out),
    .rd_en     (rd_en),
    .rd_index  (rd_index),
    .rd_data   (rd_data)
  );

  axi_wr_ctrl axi_wr_ctrl_i (
    .clk       (clk),
    .rstn      (rstn),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .min_lat   (min_lat),
    .rand_mask (rand_mask),
    .lfsr_out  (lfsr_out),
    .wr_en     (wr_en),
    .wr_index  (wr_index),
    .wr_data   (wr_data),
    .wr_strb   (wr_strb)
  );

endmodule

`default_nettype wire

/* src/axi_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module axi_wr_ctrl import mem_pkg::*; (
  input  wire                         clk,
  input  wire                         rstn,
  // AW channel
  input  wire  [`MEM_ADDR_W-1:0]      awaddr,
  input  wire                         awvalid,
  output logic                        awready,
  // W channel
  input  wire  [`MEM_DATA_W-1:0]      wdata,
  input  wire  [`MEM_DATA_W/8-1:0]    wstrb,
  input  wire                         wvalid,
  output logic                        wready,
  // B channel
  output resp_t                       bresp,
  output logic                        bvalid,
  input  wire                         bready,
  // Latency shaping
  input  wire  [7:0]                  min_lat,
  input  wire  [7:0]                  rand_mask,
  input  wire  [7:0]                  lfsr_out,
  // Array write port
  output logic                        wr_en,
  output logic [`MEM_DEPTH_LOG2-1:0]  wr_index,
  output logic [`MEM_DATA_W-1:0]      wr_data,
  output logic [`MEM_DATA_W/8-1:0]    wr_strb
);

  wr_state_t                   state;
  logic [`MEM_LAT_W-1:0]       cnt;
  logic [`MEM_LAT_W-1:0]       lat_load;
  logic [`MEM_DEPTH_LOG2-1:0]  idx_q;
  logic                        err_q;
  logic [`MEM_DATA_W-1:0]      data_q;
  logic [`MEM_DATA_W/8-1:0]    strb_q;
  logic                        oor;
  logic                        aw_hs;
  logic                        w_hs;
  logic                        b_hs;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;

  assign oor = |awaddr[`MEM_ADDR_W-1:`MEM_DEPTH_LOG2+2];

  // D - 1 extra cycles after the load, write and bvalid land on edge k + D
  assign lat_load = {{(`MEM_LAT_W-8){1'b0}}, min_lat}
                  + {{(`MEM_LAT_W-8){1'b0}}, lfsr_out & rand_mask}
                  + {{(`MEM_LAT_W-1){1'b0}}, 1'b1};

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= WR_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_hs && w_hs) begin
            state <= WR_WAIT;
            cnt   <= lat_load;
          end else if (aw_hs) begin
            state <= WR_HAVE_ADDR;
          end else if (w_hs) begin
            state <= WR_HAVE_DATA;
          end
        end
        WR_HAVE_ADDR: begin
          if (w_hs) begin
            state <= WR_WAIT;
            cnt   <= lat_load;
          end
        end
        WR_HAVE_DATA: begin
          if (aw_hs) begin
            state <= WR_WAIT;
            cnt   <= lat_load;
          end
        end
        WR_WAIT: begin
          if (cnt == '0) state <= WR_RESP; // Array written on this same edge
          else cnt <= cnt - 1'b1;
        end
        WR_RESP: begin
          if (b_hs) state <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      idx_q <= awaddr[`MEM_DEPTH_LOG2+1:2];
      err_q <= oor;
    end
    if (w_hs) begin
      data_q <= wdata;
      strb_q <= wstrb;
    end
  end

  // Each ready stays low once its own phase is in
  assign awready = (state == WR_IDLE) || (state == WR_HAVE_DATA);
  assign wready  = (state == WR_IDLE) || (state == WR_HAVE_ADDR);
  assign bvalid  = (state == WR_RESP);
  assign bresp   = err_q ? RESP_SLVERR : RESP_OKAY;

  assign wr_en    = (state == WR_WAIT) && (cnt == '0) && !err_q;
  assign wr_index = idx_q;
  assign wr_data  = data_q;
  assign wr_strb  = strb_q;

endmodule

`default_nettype wire

/* src/axi_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module axi_rd_ctrl import mem_pkg::*; (
  input  wire                         clk,
  input  wire                         rstn,
  // AR channel
  input  wire  [`MEM_ADDR_W-1:0]      araddr,
  input  wire                         arvalid,
  output logic                        arready,
  // R channel
  output logic [`MEM_DATA_W-1:0]      rdata,
  output resp_t                       rresp,
  output logic                        rvalid,
  input  wire                         rready,
  // Latency shaping
  input  wire  [7:0]                  min_lat,
  input  wire  [7:0]                  rand_mask,
  input  wire  [7:0]                  lfsr_out,
  // Array read port
  output logic                        rd_en,
  output logic [`MEM_DEPTH_LOG2-1:0]  rd_index,
  input  wire  [`MEM_DATA_W-1:0]      rd_data
);

  rd_state_t                   state;
  logic [`MEM_LAT_W-1:0]       cnt;
  logic [`MEM_LAT_W-1:0]       lat_load;
  logic [`MEM_DEPTH_LOG2-1:0]  idx_q;
  logic                        err_q;
  logic                        oor;
  logic                        ar_hs;
  logic                        r_hs;

  assign ar_hs = arvalid & arready;
  assign r_hs  = rvalid & rready;

  // Any bit above the word index means past the end of the array
  assign oor = |araddr[`MEM_ADDR_W-1:`MEM_DEPTH_LOG2+2];

  // Loading D - 2 keeps RD_WAIT for D - 1 cycles and RD_FETCH adds one more
  assign lat_load = {{(`MEM_LAT_W-8){1'b0}}, min_lat}
                  + {{(`MEM_LAT_W-8){1'b0}}, lfsr_out & rand_mask};

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= RD_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_hs) begin
            state <= RD_WAIT;
            cnt   <= lat_load;
          end
        end
        RD_WAIT: begin
          if (cnt == '0) state <= RD_FETCH;
          else cnt <= cnt - 1'b1;
        end
        RD_FETCH: state <= RD_RESP;
        RD_RESP: begin
          if (r_hs) state <= RD_IDLE;
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      idx_q <= araddr[`MEM_DEPTH_LOG2+1:2];
      err_q <= oor;
    end
  end

  assign arready  = (state == RD_IDLE);
  assign rvalid   = (state == RD_RESP);
  assign rd_en    = (state == RD_FETCH) && !err_q; // No array access on error
  assign rd_index = idx_q;

  // rd_data only changes on rd_en, so this stays put while rvalid waits
  assign rdata = err_q ? '0 : rd_data;
  assign rresp = err_q ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

/* src/sram_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module sram_array (
  input  wire                         clk,
  input  wire                         rd_en,
  input  wire  [`MEM_DEPTH_LOG2-1:0]  rd_index,
  output logic [`MEM_DATA_W-1:0]      rd_data,
  input  wire                         wr_en,
  input  wire  [`MEM_DEPTH_LOG2-1:0]  wr_index,
  input  wire  [`MEM_DATA_W-1:0]      wr_data,
  input  wire  [`MEM_DATA_W/8-1:0]    wr_strb
);

  localparam int DEPTH  = 1 << `MEM_DEPTH_LOG2;
  localparam int NBYTES = `MEM_DATA_W / 8;

  logic [`MEM_DATA_W-1:0] mem [DEPTH];

  // Registered read, data valid the cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (wr_strb[b]) begin
          mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/lat_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module lat_cfg_regs import mem_pkg::*; (
  input  wire            clk,
  input  wire            rstn,
  input  wire            cfg_we,
  input  var cfg_reg_t   cfg_addr,
  input  wire      [7:0] cfg_wdata,
  output logic     [7:0] cfg_rdata,
  output logic     [7:0] min_lat,
  output logic     [7:0] rand_mask,
  output logic     [7:0] seed,
  output logic           seed_load
);

  always_ff @(posedge clk) begin
    if (rstn) begin
      min_lat   <= 8'h00;
      rand_mask <= 8'h0f;
      seed      <= 8'haa;
      seed_load <= 1'b0;
    end else begin
      // One-cycle pulse so the LFSR picks up the new seed
      seed_load <= cfg_we && (cfg_addr == CFG_SEED);
      if (cfg_we) begin
        case (cfg_addr)
          CFG_MIN_LAT:   min_lat   <= cfg_wdata;
          CFG_RAND_MASK: rand_mask <= cfg_wdata;
          CFG_SEED:      seed      <= cfg_wdata;
          default: ; // Unmapped index ignored
        endcase
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      CFG_MIN_LAT:   cfg_rdata = min_lat;
      CFG_RAND_MASK: cfg_rdata = rand_mask;
      CFG_SEED:      cfg_rdata = seed;
      default:       cfg_rdata = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

/* src/lat_lfsr.sv */
`timescale 1ns/1ps
`default_nettype none

module lat_lfsr (
  input  wire        clk,
  input  wire        rstn,
  input  wire        seed_load,
  input  wire  [7:0] seed,
  output logic [7:0] lfsr_out
);

  logic [7:0] seed_safe;
  logic [7:0] next_state;

  // All-zero state would lock the register
  assign seed_safe = (seed == 8'h00) ? 8'h01 : seed;

  // Right-shifting Galois form of x^8 + x^6 + x^5 + x^4 + 1
  always_comb begin
    next_state = {1'b0, lfsr_out[7:1]};
    if (lfsr_out[0]) begin
      next_state = next_state ^ 8'hb8;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn || seed_load) begin
      lfsr_out <= seed_safe;
    end else begin
      lfsr_out <= next_state;
    end
  end

endmodule

`default_nettype wire

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_FETCH, // Array read issued in this cycle
    RD_RESP
  } rd_state_t;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_HAVE_ADDR, // AW taken, waiting for W
    WR_HAVE_DATA, // W taken, waiting for AW
    WR_WAIT,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    CFG_MIN_LAT   = 2'd0,
    CFG_RAND_MASK = 2'd1,
    CFG_SEED      = 2'd2
  } cfg_reg_t;

endpackage

`default_nettype wire

/* src/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Byte address seen on the AXI-lite ports
`define MEM_ADDR_W 32

// Word width of the array and the data channels
`define MEM_DATA_W 32

// 256 words
`define MEM_DEPTH_LOG2 8

// Holds min_lat plus the masked LFSR value with room to spare
`define MEM_LAT_W 9

`endif
